//--- hw/accel_params.svh
// SPI clock division, FIFO depths and the APB register map
// of the dual accelerometer reader
`ifndef ACCEL_PARAMS_SVH
`define ACCEL_PARAMS_SVH

// clk cycles per SPI tick, two ticks make one bit
`define ACCEL_CLK_DIV 4

// tag FIFO holds 2**bits characters
`define ACCEL_TAG_DEPTH_BITS 4

// parking space for the channel-1 bytes of one burst
`define ACCEL_CH1_DEPTH 16

// APB word addresses
`define ACCEL_REG_CFG    4'h0
`define ACCEL_REG_CTRL   4'h4
`define ACCEL_REG_TAG    4'h8
`define ACCEL_REG_STATUS 4'hC

`endif

//--- hw/accel_spi_pkg.sv
// sensor-side types
// burst configuration and the shared SPI pin bundle
package accel_spi_pkg;

  // one burst as seen by both sensors
  typedef struct packed {
    logic [7:0] cmd;   // command byte, sent MSB first
    logic [3:0] len;   // bytes per burst incl. command byte
    logic       cpha;  // sample on trailing sclk edge when set
    logic       cpol;  // sclk idle level
  } spi_cfg_t;         // 14 bits, laid out as in the CFG register

  // lines driven towards both sensors
  typedef struct packed {
    logic csn;   // active low select, shared
    logic sclk;  // shared clock
    logic mosi;  // shared data out
  } spi_pins_t;

endpackage

//--- hw/accel_buf_pkg.sv
// buffer-side types
// tag characters and the byte-wide buffer write beat
package accel_buf_pkg;

  // 6-bit character, ascii 0x20..0x5f range
  typedef logic [5:0] tag_char_t;

  localparam tag_char_t TAG_BANG  = 6'h21; // marks a tag pulse
  localparam tag_char_t TAG_SPACE = 6'h20; // nothing queued

  // one beat towards the BRAM, no back-pressure
  typedef struct packed {
    logic [7:0] data;  // received byte
    logic       wr;    // write strobe, one cycle per byte
    logic       x;     // reset write address before first byte
  } buf_wr_t;

endpackage

//--- hw/sync_fifo.sv
// synchronous FIFO with registered look-ahead read data
// payload type and depth set by parameters
`timescale 1ns/1ps

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 16 // power of two
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic empty,
  output logic full
);

  localparam int AW = $clog2(DEPTH);

  T            mem [DEPTH];
  logic [AW:0] wr_ptr;     // extra msb tells full from empty
  logic [AW:0] rd_ptr;
  logic [AW:0] rd_ptr_nxt; // head address after this cycle's pop

  assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, pop};
  assign full       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr[AW-1:0]] <= push_data;
    pop_data <= mem[rd_ptr_nxt[AW-1:0]]; // head is ready right after a pop
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      empty  <= 1'b1;
    end
    else
    begin
      wr_ptr <= wr_ptr + {{AW{1'b0}}, push};
      rd_ptr <= rd_ptr_nxt;
      empty  <= (rd_ptr_nxt == wr_ptr); // slot still unwritten, so pop_data not valid yet
    end
  end

  // flow control is the caller's job
  assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("sync_fifo push while full");
  assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("sync_fifo pop while empty");

endmodule

//--- hw/tag_source.sv
// tag character source for burst tagging
// pulse marker first, then queued characters, space when none
`timescale 1ns/1ps
`include "accel_params.svh"

module tag_source
  import accel_buf_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      tag_push,   // queue one character
  input  tag_char_t tag_char,
  input  logic      tag_pulse,  // request a "!" marker
  input  logic      tag_latch,  // burst start, pick a character
  output tag_char_t tag_out     // held until the next latch
);

  localparam int TAG_DEPTH = 1 << `ACCEL_TAG_DEPTH_BITS;

  logic      pulse_pend; // marker waiting for the next burst
  logic      fifo_pop;
  logic      fifo_empty;
  tag_char_t fifo_head;

  sync_fifo #(
    .T     (tag_char_t),
    .DEPTH (TAG_DEPTH)
  ) u_tag_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (tag_push),
    .push_data (tag_char),
    .pop       (fifo_pop),
    .pop_data  (fifo_head),
    .empty     (fifo_empty),
    .full      ()
  );

  assign fifo_pop = tag_latch && !pulse_pend && !fifo_empty; // marker wins over queue

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pulse_pend <= 1'b0;
      tag_out    <= TAG_SPACE;
    end
    else
    begin
      if (tag_pulse)
        pulse_pend <= 1'b1;           // a new pulse survives a same-cycle latch
      else if (tag_latch)
        pulse_pend <= 1'b0;
      if (tag_latch)
        tag_out <= pulse_pend ? TAG_BANG : fifo_empty ? TAG_SPACE : fifo_head;
    end
  end

endmodule

//--- hw/accel_spi_seq.sv
// SPI burst sequencer for two sensors on one shared bus
// MISO capture, tag insertion, channel-1 parking and buffer beats
`timescale 1ns/1ps
`include "accel_params.svh"

module accel_spi_seq
  import accel_spi_pkg::*;
  import accel_buf_pkg::*;
#(
  parameter bit tag_enable = 1'b1 // tag LSBs of every second data byte
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      sync,        // rising edge starts a burst
  input  spi_cfg_t  cfg,
  input  logic      direct_req,
  output logic      direct_en,   // sensors handed to the external mux
  output logic      busy,
  output logic      tag_latch,
  input  tag_char_t tag_in,      // held by tag_source for the whole burst
  output spi_pins_t pins,
  input  logic      miso0,
  input  logic      miso1,
  output buf_wr_t   buf_wr
);

  localparam int DIV_W = $clog2(`ACCEL_CLK_DIV);

  typedef enum logic [1:0] {ST_IDLE, ST_SPI, ST_DRAIN} state_t;

  state_t           state;
  spi_cfg_t         cfg_q;       // configuration frozen at burst start
  logic             sync_q;
  logic             start;
  logic [DIV_W-1:0] div_cnt;     // prescaler
  logic             tick;
  logic [7:0]       step;        // ticks since burst start
  logic [7:0]       step_nxt;
  logic [7:0]       last_half;   // step of the final bit's second half
  logic [7:0]       bit_idx;
  logic [3:0]       byte_idx;    // 0 is the command byte
  logic             in_bits;
  logic             nxt_in_bits;
  logic             csn_r;
  logic             sclk_r;
  logic [7:0]       mosi_sr;
  logic [7:0]       sh0;         // channel-0 shift register
  logic [7:0]       sh1;         // channel-1 shift register
  logic             byte_end;
  logic             tag_here;
  logic [2:0]       tag_i;       // counts tagged bytes from 0
  logic [15:0]      tag_ext;     // tag bits above 5 read as zero
  logic [7:0]       byte0;
  logic [7:0]       byte1;
  logic             ch1_push;
  logic             ch1_pop;
  logic             ch1_empty;
  logic [7:0]       ch1_head;

  assign start       = (state == ST_IDLE) && sync && !sync_q && !direct_en;
  assign tick        = (state == ST_SPI) && (div_cnt == DIV_W'(`ACCEL_CLK_DIV - 1));
  assign step_nxt    = step + 8'd1;
  assign last_half   = {cfg_q.len, 4'h0} + 8'd1;          // len*8 bits, two ticks each
  assign bit_idx     = (step - 8'd2) >> 1;                // bit 0 starts at step 2
  assign byte_idx    = bit_idx[6:3];
  assign in_bits     = (step >= 8'd2) && (step <= last_half);
  assign nxt_in_bits = (step_nxt >= 8'd2) && (step_nxt <= last_half);
  assign byte_end    = tick && in_bits && step[0] && (bit_idx[2:0] == 3'd7);

  // data bytes 2, 4, 6 ... carry one tag bit per channel
  assign tag_here = tag_enable && !byte_idx[0] && (byte_idx != 4'd0);
  assign tag_i    = byte_idx[3:1] - 3'd1;
  assign tag_ext  = {10'd0, tag_in};
  assign byte0    = tag_here ? {sh0[7:1], tag_ext[tag_i]} : sh0;
  assign byte1    = tag_here ? {sh1[7:1], tag_ext[tag_i + 4'd3]} : sh1;

  assign ch1_push = byte_end && (byte_idx != 4'd0);
  assign ch1_pop  = (state == ST_DRAIN) && !ch1_empty;
  assign busy     = (state != ST_IDLE);
  assign pins     = '{csn: csn_r, sclk: sclk_r, mosi: mosi_sr[7]};

  sync_fifo #(
    .T     (logic [7:0]),
    .DEPTH (`ACCEL_CH1_DEPTH)
  ) u_ch1_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (ch1_push),
    .push_data (byte1),
    .pop       (ch1_pop),
    .pop_data  (ch1_head),
    .empty     (ch1_empty),
    .full      ()
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= ST_IDLE;
      sync_q    <= 1'b0;
      div_cnt   <= '0;
      step      <= '0;
      csn_r     <= 1'b1;
      sclk_r    <= cfg.cpol;
      mosi_sr   <= '0;
      direct_en <= 1'b0;
      tag_latch <= 1'b0;
      buf_wr.wr <= 1'b0;
      buf_wr.x  <= 1'b0;
    end
    else
    begin
      sync_q    <= sync;
      tag_latch <= start && tag_enable;
      buf_wr.wr <= 1'b0;                  // beats are one-cycle pulses
      buf_wr.x  <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          sclk_r <= cfg.cpol;             // idle level tracks the live setting
          if (start)
          begin
            state   <= ST_SPI;
            cfg_q   <= cfg;
            div_cnt <= '0;
            step    <= '0;
            mosi_sr <= cfg.cmd;
          end
          else
            direct_en <= direct_req;      // grant moves only between bursts
        end
        ST_SPI:
        begin
          div_cnt <= tick ? '0 : div_cnt + 1'b1;
          if (tick)
          begin
            step   <= step_nxt;
            sclk_r <= cfg_q.cpol ^ (nxt_in_bits && (step_nxt[0] ^ cfg_q.cpha));
            if (step == 8'd0)
              csn_r <= 1'b0;              // select one tick after start
            if (step == last_half + 8'd1)
            begin
              csn_r <= 1'b1;
              state <= ST_DRAIN;
            end
            if (in_bits && !step[0])
            begin
              sh0 <= {sh0[6:0], miso0};   // capture edge, end of first half
              sh1 <= {sh1[6:0], miso1};
            end
            if (in_bits && step[0])
              mosi_sr <= {mosi_sr[6:0], 1'b0}; // next command bit, zeros after
          end
          if (byte_end)
          begin
            if (byte_idx == 4'd0)
              buf_wr.x <= 1'b1;           // address reset ahead of first data byte
            else
            begin
              buf_wr.wr   <= 1'b1;
              buf_wr.data <= byte0;
            end
          end
        end
        ST_DRAIN:
        begin
          if (ch1_pop)
          begin
            buf_wr.wr   <= 1'b1;          // parked channel-1 bytes back to back
            buf_wr.data <= ch1_head;
          end
          else
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) (state == ST_IDLE) |-> pins.csn)
    else $error("csn low outside a burst");
  assert property (@(posedge clk) disable iff (rst) start |-> (cfg.len >= 4'd2))
    else $error("burst started with len below 2");

endmodule

//--- hw/accel_apb_regs.sv
// APB slave of the accelerometer reader
// CFG and CTRL registers, tag push and pulse strobes, status readback
`timescale 1ns/1ps
`include "accel_params.svh"

module accel_apb_regs
  import accel_spi_pkg::*;
  import accel_buf_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output spi_cfg_t    cfg,
  output logic        direct_req,
  output logic        tag_push,
  output tag_char_t   tag_char,
  output logic        tag_pulse,
  input  logic        direct_en,
  input  logic        busy
);

  localparam int CW = $bits(spi_cfg_t);

  logic wr_en; // access phase of a write

  assign pready = 1'b1;                 // no wait states
  assign wr_en  = psel && penable && pwrite;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cfg        <= '{cmd: 8'h01, len: 4'd10, cpha: 1'b0, cpol: 1'b0};
      direct_req <= 1'b0;
      tag_push   <= 1'b0;
      tag_pulse  <= 1'b0;
    end
    else
    begin
      tag_push  <= wr_en && (paddr == `ACCEL_REG_TAG);
      tag_pulse <= wr_en && (paddr == `ACCEL_REG_CTRL) && pwdata[1]; // self-clearing
      if (wr_en && (paddr == `ACCEL_REG_CFG))
        cfg <= spi_cfg_t'(pwdata[CW-1:0]);
      if (wr_en && (paddr == `ACCEL_REG_CTRL))
        direct_req <= pwdata[0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en && (paddr == `ACCEL_REG_TAG))
      tag_char <= pwdata[5:0];          // valid alongside tag_push
  end

  always_comb
  begin
    prdata = '0;
    case (paddr)
      `ACCEL_REG_CFG:    prdata[CW-1:0] = cfg;
      `ACCEL_REG_CTRL:   prdata[0]      = direct_req;
      `ACCEL_REG_STATUS: prdata[1:0]    = {busy, direct_en};
      default:           prdata         = '0; // TAG is write-only
    endcase
  end

  // access phase needs its setup cycle
  assert property (@(posedge clk) disable iff (rst)
    (psel && penable) |-> $past(psel && !penable))
    else $error("APB access without setup phase");

endmodule

//--- hw/accel_reader_top.sv
// top level of the dual accelerometer reader
// APB registers, tag source and SPI burst sequencer
`timescale 1ns/1ps

module accel_reader_top
  import accel_spi_pkg::*;
  import accel_buf_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  input  logic        sync,
  output spi_pins_t   pins,
  input  logic        miso0,
  input  logic        miso1,
  output buf_wr_t     buf_wr,
  output logic        direct_en
);

  spi_cfg_t  cfg;
  logic      direct_req;
  logic      tag_push;
  tag_char_t tag_char;
  logic      tag_pulse;
  logic      tag_latch;
  tag_char_t tag_sel;    // character for the current burst
  logic      busy;

  accel_apb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .cfg        (cfg),
    .direct_req (direct_req),
    .tag_push   (tag_push),
    .tag_char   (tag_char),
    .tag_pulse  (tag_pulse),
    .direct_en  (direct_en),
    .busy       (busy)
  );

  tag_source u_tag (
    .clk       (clk),
    .rst       (rst),
    .tag_push  (tag_push),
    .tag_char  (tag_char),
    .tag_pulse (tag_pulse),
    .tag_latch (tag_latch),
    .tag_out   (tag_sel)
  );

  accel_spi_seq #(
    .tag_enable (1'b1)
  ) u_seq (
    .clk        (clk),
    .rst        (rst),
    .sync       (sync),
    .cfg        (cfg),
    .direct_req (direct_req),
    .direct_en  (direct_en),
    .busy       (busy),
    .tag_latch  (tag_latch),
    .tag_in     (tag_sel),
    .pins       (pins),
    .miso0      (miso0),
    .miso1      (miso1),
    .buf_wr     (buf_wr)
  );

endmodule

//--- verif/accel_tb.sv
// testbench of the dual accelerometer reader
// APB driver, two SPI sensor models, LFSR stimulus, reference beat model and checks
`timescale 1ns/1ps
`include "accel_params.svh"

module accel_tb
  import accel_spi_pkg::*;
  import accel_buf_pkg::*;
();

  localparam int APB_LIMIT   = 16;   // cycles allowed for pready
  localparam int BURST_LIMIT = 3000; // cycles allowed for the beats of one burst
  localparam int IDLE_LIMIT  = 200;  // STATUS polls allowed for busy to fall

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        sync;
  spi_pins_t   pins;
  logic [1:0]  miso;         // one line per sensor
  buf_wr_t     buf_wr;
  logic        direct_en;

  logic [15:0] lfsr_state;
  spi_cfg_t    cfg_now;      // configuration last written to CFG
  logic [7:0]  sens_bytes [2][16];
  logic [7:0]  sens_cmd [2]; // command byte seen by each sensor
  int          out_cnt [2];  // MISO bits sent in this burst
  int          rx_cnt [2];   // MOSI bits taken in this burst
  logic        sclk_q;
  logic        csn_q;
  int          csn_falls;
  buf_wr_t     got_q [$];    // beats seen on the buffer port
  buf_wr_t     exp_q [$];
  tag_char_t   tag_model_q [$];
  logic        pulse_model;  // tag pulse waiting for the next burst
  int          mismatches;
  int          tests_run;
  int          tests_failed;

  accel_reader_top dut (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .sync      (sync),
    .pins      (pins),
    .miso0     (miso[0]),
    .miso1     (miso[1]),
    .buf_wr    (buf_wr),
    .direct_en (direct_en)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state); // one step per bit taken
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic abort_run(input string what);
    $display("ERROR t=%0t %s", $time, what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic compare_beat(input string name, input buf_wr_t got, input buf_wr_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH t=%0t %s got data=%02h wr=%b x=%b expected data=%02h wr=%b x=%b",
               $time, name, got.data, got.wr, got.x, exp.data, exp.wr, exp.x);
      mismatches++;
    end
  endtask

  task automatic compare_cfg(input string name, input spi_cfg_t got, input spi_cfg_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH t=%0t %s got cmd=%02h len=%0d cpha=%b cpol=%b",
               $time, name, got.cmd, got.len, got.cpha, got.cpol,
               " expected cmd=%02h len=%0d cpha=%b cpol=%b",
               exp.cmd, exp.len, exp.cpha, exp.cpol);
      mismatches++;
    end
  endtask

  task automatic compare_tag(input string name, input tag_char_t got, input tag_char_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH t=%0t %s got %02h expected %02h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic compare_pins(input string name, input spi_pins_t got, input spi_pins_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH t=%0t %s got csn=%b sclk=%b mosi=%b expected csn=%b sclk=%b mosi=%b",
               $time, name, got.csn, got.sclk, got.mosi, exp.csn, exp.sclk, exp.mosi);
      mismatches++;
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH t=%0t %s got %08h expected %08h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk);
    psel    <= 1'b1;  // setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;  // access phase
    @(negedge clk);
    while (!pready && n < APB_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!pready)
      abort_run("APB write never saw pready");
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && n < APB_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!pready)
      abort_run("APB read never saw pready");
    data = prdata;    // sampled at the falling edge of the access cycle
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_cfg(input spi_cfg_t c);
    cfg_now = c;      // sensors follow the new mode from here
    apb_write(`ACCEL_REG_CFG, {18'd0, c});
  endtask

  task automatic push_tag(input tag_char_t t);
    tag_model_q.push_back(t);
    apb_write(`ACCEL_REG_TAG, {26'd0, t});
  endtask

  task automatic pulse_tag();
    pulse_model = 1'b1;
    apb_write(`ACCEL_REG_CTRL, 32'h2); // pulse bit only so the direct request stays 0
  endtask

  task automatic pulse_sync();
    @(posedge clk);
    sync <= 1'b1;
    repeat (2) @(posedge clk);
    sync <= 1'b0;
  endtask

  task automatic wait_beats(input int n);
    int cnt;
    cnt = 0;
    while (got_q.size() < n && cnt < BURST_LIMIT)
    begin
      @(posedge clk);
      cnt++;
    end
    if (got_q.size() < n)
      abort_run($sformatf("only %0d of %0d buffer beats arrived", got_q.size(), n));
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          n;
    n = 0;
    apb_read(`ACCEL_REG_STATUS, st);
    while (st[1] && n < IDLE_LIMIT)
    begin
      apb_read(`ACCEL_REG_STATUS, st);
      n++;
    end
    if (st[1])
      abort_run("busy stayed high after the burst");
  endtask

  task automatic shift_out(input int ch);
    logic [7:0] b;
    b = (out_cnt[ch] < 128) ? sens_bytes[ch][out_cnt[ch] / 8] : 8'h00; // zeros past the end
    miso[ch] <= b[7 - (out_cnt[ch] % 8)];                               // MSB first
    out_cnt[ch]++;
  endtask

  task automatic take_mosi(input int ch);
    if (rx_cnt[ch] < 8)
      sens_cmd[ch] = {sens_cmd[ch][6:0], pins.mosi};
    rx_cnt[ch]++;
  endtask

  // both sensors share csn and sclk and answer on their own MISO lines
  always @(posedge clk)
  begin : sensor_models
    logic fall;
    logic moved;
    logic lead;
    logic trail;
    fall  = csn_q && !pins.csn;
    moved = !pins.csn && (pins.sclk !== sclk_q);
    lead  = moved && (pins.sclk != cfg_now.cpol);  // away from idle level
    trail = moved && (pins.sclk == cfg_now.cpol);  // back to idle level
    if (!rst)
    begin
      if (fall)
        csn_falls++;
      for (int ch = 0; ch < 2; ch++)
      begin
        if (fall)
        begin
          out_cnt[ch] = 0;
          rx_cnt[ch]  = 0;
        end
        if (cfg_now.cpha ? trail : lead)
          take_mosi(ch);                           // sample edge
        if (fall ? !cfg_now.cpha : (cfg_now.cpha ? lead : trail))
          shift_out(ch);                           // launch edge or select fall for cpha 0
      end
    end
    sclk_q = pins.sclk;
    csn_q  = pins.csn;
  end

  always @(posedge clk)
  begin : beat_monitor
    buf_wr_t beat;
    beat = buf_wr;
    if (!rst && (beat.wr || beat.x))
    begin
      if (!beat.wr)
        beat.data = 8'h00;                         // data is don't-care on the x beat
      got_q.push_back(beat);
    end
  end

  // tag chosen at burst start with pulse before queue before space
  function automatic tag_char_t next_tag();
    tag_char_t t;
    if (pulse_model)
      t = TAG_BANG;
    else if (tag_model_q.size() > 0)
      t = tag_model_q.pop_front();
    else
      t = TAG_SPACE;
    pulse_model = 1'b0;
    return t;
  endfunction

  function automatic logic [7:0] expect_byte(input int ch, input int d, input tag_char_t t);
    logic [7:0] b;
    int         j;
    b = sens_bytes[ch][d];
    if (d % 2 == 0)
    begin
      j    = d / 2 - 1 + (ch == 1 ? 3 : 0);         // channel 1 carries the upper bits
      b[0] = (j < 6) ? t[j] : 1'b0;
    end
    return b;
  endfunction

  function automatic void build_expected(input spi_cfg_t c, input tag_char_t t);
    buf_wr_t beat;
    exp_q.delete();
    beat   = '0;
    beat.x = 1'b1;                                 // address reset first
    exp_q.push_back(beat);
    for (int ch = 0; ch < 2; ch++)
    begin
      for (int d = 1; d < c.len; d++)
      begin
        beat.data = expect_byte(ch, d, t);
        beat.wr   = 1'b1;
        beat.x    = 1'b0;
        exp_q.push_back(beat);
      end
    end
  endfunction

  // rebuild the tag from the LSBs of data bytes 2, 4 and 6 of both channels
  function automatic tag_char_t received_tag(input int len);
    tag_char_t t;
    for (int i = 0; i < 3; i++)
    begin
      t[i]     = got_q[2 * i + 2].data[0];
      t[i + 3] = got_q[len + 2 * i + 1].data[0];
    end
    return t;
  endfunction

  task automatic run_burst(input string name);
    tag_char_t t;
    for (int ch = 0; ch < 2; ch++)
    begin
      for (int i = 0; i < 16; i++)
        sens_bytes[ch][i] = 8'(rand_bits(8));
      sens_cmd[ch] = 8'h00;
    end
    got_q.delete();
    t = next_tag();
    pulse_sync();
    wait_beats(2 * cfg_now.len - 1);
    wait_idle();
    build_expected(cfg_now, t);
    compare_word({name, " beat count"}, got_q.size(), exp_q.size());
    if (got_q.size() == exp_q.size())
    begin
      for (int i = 0; i < exp_q.size(); i++)
        compare_beat($sformatf("%s beat %0d", name, i), got_q[i], exp_q[i]);
      if (cfg_now.len >= 7)
        compare_tag({name, " tag"}, received_tag(cfg_now.len), t);
    end
    compare_word({name, " sensor 0 cmd"}, {24'd0, sens_cmd[0]}, {24'd0, cfg_now.cmd});
    compare_word({name, " sensor 1 cmd"}, {24'd0, sens_cmd[1]}, {24'd0, cfg_now.cmd});
  endtask

  task automatic finish_test(input string title, input int errs_before);
    tests_run++;
    if (mismatches == errs_before)
      $display("test %0d %s: ok", tests_run, title);
    else
    begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d mismatches", tests_run, title,
               mismatches - errs_before);
    end
  endtask

  initial
  begin : main
    logic [31:0] rd;
    spi_cfg_t    c;
    spi_cfg_t    got_cfg;
    spi_pins_t   idle_pins;
    tag_char_t   t0;
    tag_char_t   t1;
    int          e;
    int          falls0;
    rst          = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = 4'h0;
    pwdata       = 32'h0;
    sync         = 1'b0;
    miso         = 2'b00;
    lfsr_state   = 16'd61953;
    cfg_now.cmd  = 8'h01;                          // register reset value
    cfg_now.len  = 4'd10;
    cfg_now.cpha = 1'b0;
    cfg_now.cpol = 1'b0;
    sclk_q       = 1'b0;
    csn_q        = 1'b1;
    csn_falls    = 0;
    pulse_model  = 1'b0;
    mismatches   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    e = mismatches;
    apb_read(`ACCEL_REG_STATUS, rd);
    compare_word("STATUS after reset", rd, 32'h0);
    c.cmd  = 8'(rand_bits(8));
    c.len  = 4'(3 + rand_bits(3));                 // 3 to 10
    c.cpha = 1'b0;
    c.cpol = 1'b0;
    write_cfg(c);
    apb_read(`ACCEL_REG_CFG, rd);
    got_cfg = rd[13:0];
    compare_cfg("CFG readback", got_cfg, c);
    finish_test("config readback and reset status", e);

    e = mismatches;
    run_burst("empty tag fifo burst");
    finish_test("burst with empty tag fifo", e);

    e = mismatches;
    c.len = 4'(7 + rand_bits(2));                  // long enough to carry all six tag bits
    write_cfg(c);
    for (int i = 0; i < 3; i++)
      push_tag(6'(rand_bits(6)));
    for (int i = 0; i < 4; i++)
      run_burst($sformatf("queued tag burst %0d", i));
    finish_test("queued tag characters then space", e);

    e = mismatches;
    t0 = 6'(rand_bits(6));
    t1 = 6'(rand_bits(6));
    push_tag(t0);
    pulse_tag();
    push_tag(t1);
    for (int i = 0; i < 3; i++)
      run_burst($sformatf("pulse tag burst %0d", i));
    finish_test("tag pulse ahead of queue", e);

    e = mismatches;
    apb_write(`ACCEL_REG_CTRL, 32'h1);
    apb_read(`ACCEL_REG_STATUS, rd);
    compare_word("STATUS in direct mode", rd, 32'h1);
    compare_word("direct_en in direct mode", {31'd0, direct_en}, 32'h1);
    falls0 = csn_falls;
    got_q.delete();
    pulse_sync();
    repeat (BURST_LIMIT) @(posedge clk);           // quiet window where nothing may start
    compare_word("csn falls in direct mode", csn_falls - falls0, 0);
    compare_word("beats in direct mode", got_q.size(), 0);
    apb_write(`ACCEL_REG_CTRL, 32'h0);
    apb_read(`ACCEL_REG_STATUS, rd);
    compare_word("STATUS after direct mode", rd, 32'h0);
    compare_word("direct_en after direct mode", {31'd0, direct_en}, 32'h0);
    run_burst("burst after direct mode");
    finish_test("direct mode blocks bursts", e);

    e = mismatches;
    for (int i = 0; i < 6; i++)
    begin
      c.cmd  = 8'(rand_bits(8));
      c.len  = 4'(3 + rand_bits(3));
      c.cpha = 1'(rand_bits(1));
      c.cpol = 1'(rand_bits(1));
      write_cfg(c);
      repeat (2) @(posedge clk);
      @(negedge clk);
      idle_pins.csn  = 1'b1;
      idle_pins.sclk = c.cpol;                     // sclk parks at cpol
      idle_pins.mosi = 1'b0;
      compare_pins($sformatf("idle pins %0d", i), pins, idle_pins);
      run_burst($sformatf("mode burst %0d", i));
    end
    finish_test("random clock phase and polarity", e);

    $display("tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, mismatches);
    if (tests_failed == 0 && mismatches == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
+incdir+hw
hw/accel_spi_pkg.sv
hw/accel_buf_pkg.sv
hw/sync_fifo.sv
hw/tag_source.sv
hw/accel_spi_seq.sv
hw/accel_apb_regs.sv
hw/accel_reader_top.sv
verif/accel_tb.sv
